/* hw/sapConfig.svh */
// widths and sizes of the 4-bit teaching CPU, included by the package and the RTL
`ifndef SAP_CONFIG_SVH
`define SAP_CONFIG_SVH

// data path is one nibble wide
`define SAP_DATA_W 4

// operand field addresses the whole memory
`define SAP_ADDR_W 4

// opcode nibble on top of the operand nibble
`define SAP_INSTR_W 8

// words of program memory, one per address
`define SAP_MEM_DEPTH 16

// the instruction format ties these together:
// SAP_INSTR_W is the opcode width plus SAP_ADDR_W,
// SAP_MEM_DEPTH is 2 to the power of SAP_ADDR_W,
// a store writes SAP_DATA_W bits zero-extended to SAP_INSTR_W

`endif

/* hw/sapPkg.sv */
// shared types of the CPU: data, address and instruction words, opcodes, timing states
`default_nettype none

`include "sapConfig.svh"

package sapPkg;

  typedef logic [`SAP_DATA_W-1:0]  dataT;   // register and ALU word
  typedef logic [`SAP_ADDR_W-1:0]  addrT;   // PC, MAR and operand field
  typedef logic [`SAP_INSTR_W-1:0] instrT;  // memory word, opcode in upper half

  // opcode nibble, codes not listed run as no-ops
  typedef enum logic [3:0] {
    OP_ADD   = 4'd1,   // A = A + B
    OP_SUB   = 4'd2,   // A = A - B
    OP_XCHG  = 4'd3,   // swap A and B through TMP
    OP_STORE = 4'd6,   // mem[addr] = A
    OP_LOAD  = 4'd7,   // A = mem[addr]
    OP_AND   = 4'd8,   // A = A & B
    OP_ORMEM = 4'd9,   // B = B | mem[addr]
    OP_OUT   = 4'd10,  // OUT = A
    OP_HLT   = 4'd15
  } opcodeT;

  // one-hot ring counter, one instruction per full turn
  typedef enum logic [5:0] {
    T1 = 6'b000001,  // MAR from PC
    T2 = 6'b000010,  // PC increment
    T3 = 6'b000100,  // IR load
    T4 = 6'b001000,
    T5 = 6'b010000,
    T6 = 6'b100000
  } tStateT;

endpackage

`default_nettype wire

/* hw/controlUnit.sv */
// control sequencer of the CPU: instruction register, T1..T6 ring counter, halt and decode
`timescale 1ns/100ps
`default_nettype none

`include "sapConfig.svh"

module controlUnit import sapPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   load,
  input  instrT  memWord,
  output logic   marFromPc,
  output logic   pcInc,
  output logic   irLoad,
  output logic   marFromIr,
  output logic   aFromMem,
  output logic   memWrite,
  output logic   aFromAlu,
  output logic   aFromB,
  output logic   tmpFromA,
  output logic   tmpFromMem,
  output logic   bFromTmp,
  output logic   bFromOr,
  output logic   outLoad,
  output opcodeT aluOp,
  output addrT   irAddr,
  output logic   halted
);

  instrT  instrReg;
  tStateT state;
  opcodeT opcode;
  logic   haltSet;  // HLT seen in T4

  assign opcode = opcodeT'(instrReg[`SAP_INSTR_W-1:`SAP_ADDR_W]);
  assign aluOp  = opcode;
  assign irAddr = instrReg[`SAP_ADDR_W-1:0];  // operand half

  always_ff @(posedge clk)
  begin
    if (!reset)
      instrReg <= '0;  // opcode 0 decodes as no-op
    else if (irLoad)
      instrReg <= memWord;
  end

  // ring counter, parked in T1 during program load and after halt
  always_ff @(posedge clk)
  begin
    if (!reset)
      state <= T1;
    else if (load || halted || haltSet)
      state <= T1;
    else
    begin
      case (state)
        T1:      state <= T2;
        T2:      state <= T3;
        T3:      state <= T4;
        T4:      state <= T5;
        T5:      state <= T6;
        default: state <= T1;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
      halted <= 1'b0;
    else if (haltSet)
      halted <= 1'b1;  // sticky until reset
  end

  // enable decode, everything low unless the state and opcode ask for it
  always_comb
  begin
    marFromPc  = 1'b0;
    pcInc      = 1'b0;
    irLoad     = 1'b0;
    marFromIr  = 1'b0;
    aFromMem   = 1'b0;
    memWrite   = 1'b0;
    aFromAlu   = 1'b0;
    aFromB     = 1'b0;
    tmpFromA   = 1'b0;
    tmpFromMem = 1'b0;
    bFromTmp   = 1'b0;
    bFromOr    = 1'b0;
    outLoad    = 1'b0;
    haltSet    = 1'b0;
    if (!halted)
    begin
      if (load)
        marFromPc = 1'b1;  // MAR just tracks PC while loading
      else
      begin
        case (state)
          T1: marFromPc = 1'b1;
          T2: pcInc     = 1'b1;
          T3: irLoad    = 1'b1;
          T4:
          begin
            case (opcode)
              OP_LOAD, OP_STORE, OP_ORMEM: marFromIr = 1'b1;
              OP_ADD, OP_SUB, OP_AND:      aFromAlu  = 1'b1;
              OP_XCHG:                     tmpFromA  = 1'b1;
              OP_OUT:                      outLoad   = 1'b1;
              OP_HLT:                      haltSet   = 1'b1;
              default: ;
            endcase
          end
          T5:
          begin
            case (opcode)
              OP_LOAD:  aFromMem   = 1'b1;
              OP_STORE: memWrite   = 1'b1;
              OP_ORMEM: tmpFromMem = 1'b1;
              OP_XCHG:  aFromB     = 1'b1;  // old A already in TMP
              default: ;
            endcase
          end
          T6:
          begin
            case (opcode)
              OP_ORMEM: bFromOr  = 1'b1;
              OP_XCHG:  bFromTmp = 1'b1;
              default: ;
            endcase
          end
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* hw/addressUnit.sv */
// address path of the CPU: program counter and memory address register
`timescale 1ns/100ps
`default_nettype none

module addressUnit import sapPkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic pcInc,
  input  logic marFromPc,
  input  logic marFromIr,
  input  addrT irAddr,
  output addrT marAddr
);

  addrT pc;
  addrT mar;

  assign marAddr = mar;

  // wraps from 15 back to 0 by width
  always_ff @(posedge clk)
  begin
    if (!reset)
      pc <= '0;
    else if (pcInc)
      pc <= pc + 1'b1;
  end

  // operand address during execute, PC during fetch
  always_ff @(posedge clk)
  begin
    if (!reset)
      mar <= '0;
    else if (marFromIr)
      mar <= irAddr;
    else if (marFromPc)
      mar <= pc;
  end

endmodule

`default_nettype wire

/* hw/programMemory.sv */
// program and data memory of the CPU, written by the load port or a store from A
`timescale 1ns/100ps
`default_nettype none

`include "sapConfig.svh"

module programMemory import sapPkg::*;
(
  input  logic  clk,
  input  logic  load,
  input  logic  memWrite,
  input  addrT  loadAddr,
  input  addrT  marAddr,
  input  instrT loadData,
  input  dataT  aValue,
  output instrT memWord
);

  instrT mem [`SAP_MEM_DEPTH];
  instrT storeWord;

  // upper nibble cleared on a store
  assign storeWord = {{(`SAP_INSTR_W-`SAP_DATA_W){1'b0}}, aValue};

  // load port wins over a store in the same cycle
  always_ff @(posedge clk)
  begin
    if (load)
      mem[loadAddr] <= loadData;
    else if (memWrite)
      mem[marAddr] <= storeWord;
  end

  assign memWord = mem[marAddr];  // async read

endmodule

`default_nettype wire

/* hw/dataPath.sv */
// data path of the CPU: registers A, B and TMP, the ALU and the output register
`timescale 1ns/100ps
`default_nettype none

module dataPath import sapPkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   aFromMem,
  input  logic   aFromAlu,
  input  logic   aFromB,
  input  logic   tmpFromA,
  input  logic   tmpFromMem,
  input  logic   bFromTmp,
  input  logic   bFromOr,
  input  logic   outLoad,
  input  dataT   memData,
  input  opcodeT aluOp,
  output dataT   aValue,
  output dataT   outValue,
  output logic   outStrobe
);

  dataT regA;
  dataT regB;
  dataT regTmp;
  dataT regOut;
  dataT aluResult;

  // all results are modulo 16 by width
  always_comb
  begin
    case (aluOp)
      OP_ADD:   aluResult = regA + regB;
      OP_SUB:   aluResult = regA - regB;
      OP_AND:   aluResult = regA & regB;
      OP_ORMEM: aluResult = regTmp | regB;  // TMP holds the memory operand
      default:  aluResult = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
      regA <= '0;
    else if (aFromMem)
      regA <= memData;
    else if (aFromAlu)
      regA <= aluResult;
    else if (aFromB)
      regA <= regB;
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
      regTmp <= '0;
    else if (tmpFromA)
      regTmp <= regA;  // first half of XCHG
    else if (tmpFromMem)
      regTmp <= memData;
  end

  always_ff @(posedge clk)
  begin
    if (!reset)
      regB <= '0;
    else if (bFromTmp)
      regB <= regTmp;
    else if (bFromOr)
      regB <= aluResult;
  end

  // output latch, value visible the cycle after the strobe
  always_ff @(posedge clk)
  begin
    if (!reset)
      regOut <= '0;
    else if (outLoad)
      regOut <= regA;
  end

  assign aValue    = regA;
  assign outValue  = regOut;
  assign outStrobe = outLoad;  // high in T4 of OUT only

endmodule

`default_nettype wire

/* hw/sapCpu.sv */
// top level of the 4-bit teaching CPU, connects control, address path, memory and data path
`timescale 1ns/100ps
`default_nettype none

`include "sapConfig.svh"

module sapCpu import sapPkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  load,      // level, holds the CPU while memory is written
  input  addrT  loadAddr,
  input  instrT loadData,
  output dataT  outValue,
  output logic  outStrobe,
  output logic  halted
);

  logic   marFromPc;
  logic   pcInc;
  logic   irLoad;
  logic   marFromIr;
  logic   aFromMem;
  logic   memWrite;
  logic   aFromAlu;
  logic   aFromB;
  logic   tmpFromA;
  logic   tmpFromMem;
  logic   bFromTmp;
  logic   bFromOr;
  logic   outLoad;
  opcodeT aluOp;
  addrT   irAddr;
  addrT   marAddr;
  instrT  memWord;
  dataT   aValue;

  controlUnit controlUnit_i (
    .clk, .reset, .load, .memWord,
    .marFromPc, .pcInc, .irLoad, .marFromIr, .aFromMem, .memWrite,
    .aFromAlu, .aFromB, .tmpFromA, .tmpFromMem, .bFromTmp, .bFromOr,
    .outLoad, .aluOp, .irAddr, .halted
  );

  addressUnit addressUnit_i (
    .clk, .reset, .pcInc, .marFromPc, .marFromIr, .irAddr, .marAddr
  );

  programMemory programMemory_i (
    .clk, .load, .memWrite, .loadAddr, .marAddr, .loadData, .aValue, .memWord
  );

  // data path sees only the low nibble of a memory word
  dataPath dataPath_i (
    .clk, .reset, .aFromMem, .aFromAlu, .aFromB, .tmpFromA, .tmpFromMem,
    .bFromTmp, .bFromOr, .outLoad,
    .memData (memWord[`SAP_DATA_W-1:0]),
    .aluOp, .aValue, .outValue, .outStrobe
  );

endmodule

`default_nettype wire

/* verification/sapCpuTb.sv */
// testbench of the CPU that loads each program of the table, runs it and checks OUT values and halt
`timescale 1ns/100ps
`default_nettype none

`include "sapConfig.svh"

module sapCpuTb import sapPkg::*;
();

  localparam int NUM_ROWS     = 7;
  localparam int RAND_ROW     = 6;
  localparam int RESET_CYCLES = 8;
  localparam int STEP_LIMIT   = 200;  // cycles allowed between two events
  localparam int HALT_WATCH   = 30;
  localparam instrT HLT_WORD  = 8'hF0;

  logic  clk;
  logic  reset;
  logic  load;
  addrT  loadAddr;
  instrT loadData;
  dataT  outValue;
  logic  outStrobe;
  logic  halted;

  integer seed;

  // one program per row with HLT loaded past its length
  instrT progWords [NUM_ROWS][`SAP_MEM_DEPTH] = '{
    // LOAD 3, OUT, HLT, data 35
    '{8'h73, 8'hA0, 8'hF0, 8'h35, 8'h00, 8'h00, 8'h00, 8'h00,
      8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
    // B = 12, A = 9, then ADD, SUB, AND each followed by OUT
    '{8'h7C, 8'h30, 8'h7D, 8'h10, 8'hA0, 8'h7D, 8'h20, 8'hA0,
      8'h7D, 8'h80, 8'hA0, 8'hF0, 8'h0C, 8'h09, 8'h00, 8'h00},
    // B = 3, A = 10, OUT around two exchanges
    '{8'h79, 8'h30, 8'h7A, 8'hA0, 8'h30, 8'hA0, 8'h30, 8'hA0,
      8'hF0, 8'h03, 8'h0A, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
    // B = 5 | mem[13], store 6 to 15 and read it back
    '{8'h7C, 8'h30, 8'h9D, 8'h30, 8'hA0, 8'h7E, 8'h6F, 8'h7C,
      8'hA0, 8'h7F, 8'hA0, 8'hF0, 8'h05, 8'hC9, 8'h06, 8'h0F},
    // unused opcodes 4 and 0 between LOAD and OUT
    '{8'h75, 8'h40, 8'h00, 8'hA0, 8'hF0, 8'h0B, 8'h00, 8'h00,
      8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
    // all HLT
    '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
      8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
    // filled at run time with a random ADD
    '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
      8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00}
  };
  int   progLength [NUM_ROWS]    = '{4, 14, 11, 16, 6, 0, 8};
  int   outCount   [NUM_ROWS]    = '{1, 3, 3, 3, 1, 0, 1};
  dataT outExpect  [NUM_ROWS][4] = '{
    '{4'd5,  4'd0,  4'd0,  4'd0},
    '{4'd5,  4'd13, 4'd8,  4'd0},  // 21 mod 16, -3 mod 16, 1001 & 1100
    '{4'd10, 4'd3,  4'd10, 4'd0},
    '{4'd13, 4'd5,  4'd6,  4'd0},  // 0101 | 1001
    '{4'd11, 4'd0,  4'd0,  4'd0},
    '{4'd0,  4'd0,  4'd0,  4'd0},
    '{4'd0,  4'd0,  4'd0,  4'd0}
  };

  sapCpu dut_i (
    .clk, .reset, .load, .loadAddr, .loadData, .outValue, .outStrobe, .halted
  );

  always #2 clk = ~clk;

  task automatic stopOnFailure();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic reportTimeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    stopOnFailure();
  endtask

  task automatic compareData(input string name, input dataT expected, input dataT actual);
    if (actual !== expected)
    begin
      $display("Error at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
      stopOnFailure();
    end
  endtask

  task automatic verifyFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("Error at %0t: %s expected %b, actual %b", $time, name, expected, actual);
      stopOnFailure();
    end
  endtask

  task automatic matchCount(input string name, input int expected, input int actual);
    if (actual != expected)
    begin
      $display("Error at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
      stopOnFailure();
    end
  endtask

  // ADD of two random operands with a modulo-16 result
  task automatic buildRandomRow();
    int   randValue;
    int   sum;
    dataT opA;
    dataT opB;
    randValue = $random(seed);
    opA = randValue[3:0];
    randValue = $random(seed);
    opB = randValue[3:0];
    progWords[RAND_ROW][0] = 8'h76;  // LOAD 6
    progWords[RAND_ROW][1] = 8'h30;  // XCHG, operand into B
    progWords[RAND_ROW][2] = 8'h77;  // LOAD 7
    progWords[RAND_ROW][3] = 8'h10;  // ADD
    progWords[RAND_ROW][4] = 8'hA0;  // OUT
    progWords[RAND_ROW][5] = HLT_WORD;
    progWords[RAND_ROW][6] = {4'h0, opB};
    progWords[RAND_ROW][7] = {4'h0, opA};
    sum = (int'(opA) + int'(opB)) % 16;
    outExpect[RAND_ROW][0] = sum[3:0];
  endtask

  task automatic applyReset();
    @(negedge clk);
    reset = 1'b0;
    load  = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b1;
  endtask

  task automatic loadProgram(input int row);
    for (int addr = 0; addr < `SAP_MEM_DEPTH; addr++)
    begin
      load     = 1'b1;
      loadAddr = addrT'(addr);
      if (addr < progLength[row])
        loadData = progWords[row][addr];
      else
        loadData = HLT_WORD;  // padding
      @(negedge clk);
    end
    load = 1'b0;
  endtask

  // collect OUT values until halt, then watch for stray strobes
  task automatic runProgram(input int row);
    int seen;
    int waited;
    seen   = 0;
    waited = 0;
    while (!halted)
    begin
      @(negedge clk);
      waited++;
      if (waited > STEP_LIMIT)
        reportTimeout("no outStrobe and no halted while the program ran");
      if (outStrobe)
      begin
        if (seen >= outCount[row])
          matchCount("outStrobe count", outCount[row], seen + 1);  // one pulse too many
        @(negedge clk);  // output register loads at the end of T4
        compareData("outValue", outExpect[row][seen], outValue);
        verifyFlag("outStrobe", 1'b0, outStrobe);  // single-cycle pulse
        seen++;
        waited = 0;
      end
    end
    for (int cycle = 0; cycle < HALT_WATCH; cycle++)
    begin
      @(negedge clk);
      verifyFlag("outStrobe", 1'b0, outStrobe);
      verifyFlag("halted", 1'b1, halted);
    end
    matchCount("outStrobe count", outCount[row], seen);
  endtask

  initial
  begin
    clk      = 1'b0;
    reset    = 1'b0;
    load     = 1'b0;
    loadAddr = '0;
    loadData = '0;
    seed     = 48056;
    buildRandomRow();
    for (int row = 0; row < NUM_ROWS; row++)
    begin
      applyReset();
      verifyFlag("halted", 1'b0, halted);
      loadProgram(row);
      runProgram(row);
      $display("program %0d done at %0t", row, $time);
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+hw
hw/sapPkg.sv
hw/controlUnit.sv
hw/addressUnit.sv
hw/programMemory.sv
hw/dataPath.sv
hw/sapCpu.sv
verification/sapCpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the CPU testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir &&
  verilator --binary --timing -Wno-fatal -j 0 -f all.f --top-module sapCpuTb &&
  ./obj_dir/VsapCpuTb 2>&1 | tee /dev/stderr | grep -x "test passed" > /dev/null &&
  echo "simulation PASS" ||
  { echo "simulation FAIL"; exit 1; }
